// File: rtl/isaPkg.sv
package isaPkg;

    localparam int nibbleW = 4;
    localparam int regIdxW = 4;

    typedef logic [nibbleW-1:0] nibble_t;

    // Upper instruction nibble, full 4004 map so decode stays total
    typedef enum logic [3:0] {
        NOP, JCN, SRC, FIN, JUN, JMS, INC, ISZ,
        ADD, SUB, LD, XCH, BBL, LDM, EGRP, FGRP
    } oprE;

    // Accumulator group, opa field under FGRP
    typedef enum logic [3:0] {
        CLB = 4'h0, CLC = 4'h1, IAC = 4'h2, CMC = 4'h3,
        CMA = 4'h4, RAL = 4'h5, RAR = 4'h6, TCC = 4'h7,
        DAC = 4'h8, STC = 4'hA
    } fOpE;

    // RAM group, opa field under EGRP
    typedef enum logic [3:0] {
        WRM = 4'h0,
        SBM = 4'h8,
        RDM = 4'h9,
        ADM = 4'hB
    } eOpE;

    typedef enum logic [3:0] {
        PASSB, ADDC, SUBB, INCB,
        CLR, INCA, DECA, CMPA,
        ROTL, ROTR, TCCA       // TCCA moves carry into the accumulator
    } aluOpE;

endpackage

// File: rtl/memPkg.sv
package memPkg;

    localparam int ramAddrW = 4;
    localparam int ramDepth = 16;

    typedef logic [ramAddrW-1:0] ramAddr_t;

    // Peers sharing the data RAM
    typedef enum logic {
        CORE,
        HOST
    } requesterE;

endpackage

// File: rtl/memReqIf.sv
`timescale 1ns/100ps

interface memReqIf;
    import isaPkg::*;
    import memPkg::*;

    logic     valid;
    logic     ready;
    logic     write;
    ramAddr_t addr;
    nibble_t  wdata;
    nibble_t  rdata;    // Valid while rvalid is high
    logic     rvalid;   // One cycle after a read transfer

    modport requester (
        output valid, write, addr, wdata,
        input  ready, rdata, rvalid
    );

    modport arbiter (
        input  valid, write, addr, wdata,
        output ready, rdata, rvalid
    );

endinterface

// File: rtl/nibbleAlu.sv
`timescale 1ns/100ps

module nibbleAlu (
    input  isaPkg::aluOpE  aluOp,
    input  isaPkg::nibble_t accIn,
    input  isaPkg::nibble_t aluB,
    input  logic           carryIn,
    output isaPkg::nibble_t aluResult,
    output logic           aluCarry
);
    import isaPkg::*;

    nibble_t notB;

    // Inverted here so the 5-bit sum below does not widen it
    assign notB = ~aluB;

    always_comb begin
        aluResult = aluB;
        aluCarry  = carryIn;
        case (aluOp)
            PASSB: begin
                aluResult = aluB;
                aluCarry  = carryIn;
            end
            ADDC: {aluCarry, aluResult} = accIn + aluB + carryIn;
            // Carry set means no borrow
            SUBB: {aluCarry, aluResult} = accIn + notB + carryIn;
            INCB: {aluCarry, aluResult} = aluB + 1'b1;
            CLR:  {aluCarry, aluResult} = '0;
            INCA: {aluCarry, aluResult} = accIn + 1'b1;      // Carry on wrap
            DECA: {aluCarry, aluResult} = accIn + {nibbleW{1'b1}};
            CMPA: begin
                aluResult = ~accIn;
                aluCarry  = carryIn;
            end
            // Rotates go through the carry bit
            ROTL: {aluCarry, aluResult} = {accIn, carryIn};
            ROTR: {aluResult, aluCarry} = {carryIn, accIn};
            TCCA: begin
                aluResult = {{(nibbleW-1){1'b0}}, carryIn};
                aluCarry  = 1'b0;
            end
            default: begin
                aluResult = aluB;
                aluCarry  = carryIn;
            end
        endcase
    end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/100ps

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [isaPkg::regIdxW-1:0] rdIdx,
    input  logic                       we,
    input  logic [isaPkg::regIdxW-1:0] wrIdx,
    input  isaPkg::nibble_t            wdata,
    output isaPkg::nibble_t            rdata
);
    import isaPkg::*;

    localparam int NumRegs = 1 << regIdxW;

    nibble_t regs [NumRegs];

    assign rdata = regs[rdIdx];   // Combinational read

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wrIdx] <= wdata;
        end
    end

endmodule

// File: rtl/dataRam.sv
`timescale 1ns/100ps

module dataRam #(
    parameter int RamDepth = memPkg::ramDepth
) (
    input  logic                        clk,
    input  logic                        we,
    input  logic [$clog2(RamDepth)-1:0] addr,
    input  isaPkg::nibble_t             wdata,
    output isaPkg::nibble_t             rdata
);
    import isaPkg::*;

    nibble_t mem [RamDepth];

    always_ff @(posedge clk) begin
        if (we) mem[addr] <= wdata;
        rdata <= mem[addr];   // Old data on a same-address write
    end

endmodule

// File: rtl/ramArbiter.sv
`timescale 1ns/100ps

module ramArbiter #(
    parameter int RamDepth = memPkg::ramDepth
) (
    input  logic                        clk,
    input  logic                        rstN,
    memReqIf.arbiter                    core,
    memReqIf.arbiter                    host,
    output logic                        ramWe,
    output logic [$clog2(RamDepth)-1:0] ramAddr,
    output isaPkg::nibble_t             ramWdata,
    input  isaPkg::nibble_t             ramRdata
);
    import memPkg::*;

    localparam int AddrW = $clog2(RamDepth);

    requesterE winner;
    requesterE lastWinner;
    requesterE readOwner;
    logic      readPending;
    logic      xfer;
    logic      winnerWrite;

    // Round robin on contention, lone requester served at once
    always_comb begin
        if (core.valid && host.valid) begin
            winner = (lastWinner == CORE) ? HOST : CORE;
        end else if (core.valid) begin
            winner = CORE;
        end else begin
            winner = HOST;
        end
    end

    assign core.ready  = core.valid && (winner == CORE);
    assign host.ready  = host.valid && (winner == HOST);
    assign xfer        = core.ready || host.ready;
    assign winnerWrite = (winner == CORE) ? core.write : host.write;

    assign ramWe    = xfer && winnerWrite;
    assign ramAddr  = (winner == CORE) ? core.addr[AddrW-1:0] : host.addr[AddrW-1:0];
    assign ramWdata = (winner == CORE) ? core.wdata : host.wdata;

    // ------------------------------------------------------------
    // Read response routing
    // ------------------------------------------------------------
    assign core.rdata  = ramRdata;
    assign host.rdata  = ramRdata;
    assign core.rvalid = readPending && (readOwner == CORE);
    assign host.rvalid = readPending && (readOwner == HOST);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastWinner  <= HOST;   // Core wins the first tie
            readOwner   <= CORE;
            readPending <= 1'b0;
        end else begin
            readPending <= xfer && !winnerWrite;
            if (xfer) begin
                lastWinner <= winner;
                readOwner  <= winner;
            end
        end
    end

endmodule

// File: rtl/instDecoder.sv
`timescale 1ns/100ps

module instDecoder (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       instValid,
    input  isaPkg::nibble_t            instOpr,
    input  isaPkg::nibble_t            instOpa,
    output logic                       instReady,
    output logic [isaPkg::regIdxW-1:0] regIdx,
    input  isaPkg::nibble_t            regRdata,
    output logic                       regWe,
    output isaPkg::nibble_t            regWdata,
    output isaPkg::aluOpE              aluOp,
    output isaPkg::nibble_t            aluB,
    input  isaPkg::nibble_t            aluResult,
    input  logic                       aluCarry,
    output isaPkg::nibble_t            acc,
    output logic                       carry,
    memReqIf.requester                 mem
);
    import isaPkg::*;
    import memPkg::*;

    typedef enum logic [1:0] {IDLE, EXEC, MEMREQ, MEMWAIT} stateE;

    stateE    state;
    oprE      oprQ;
    nibble_t  opaQ;
    ramAddr_t addrLatch;
    logic     accWe;
    logic     carryWe;
    logic     carryNext;
    logic     isSrc;
    logic     isRamOp;
    logic     isRamRead;

    assign instReady = (state == IDLE);
    assign regIdx    = opaQ[regIdxW-1:0];
    assign regWdata  = (oprQ == XCH) ? acc : aluResult;   // XCH swaps on one edge

    assign mem.valid = (state == MEMREQ);
    assign mem.write = !isRamRead;
    assign mem.addr  = addrLatch;
    assign mem.wdata = acc;

    always_ff @(posedge clk) begin
        if (instValid && instReady) begin
            oprQ <= oprE'(instOpr);
            opaQ <= instOpa;
        end
    end

    // ------------------------------------------------------------
    // Opcode decode
    // ------------------------------------------------------------
    always_comb begin
        aluOp     = PASSB;
        aluB      = regRdata;
        accWe     = 1'b0;
        carryWe   = 1'b0;
        carryNext = aluCarry;
        regWe     = 1'b0;
        isSrc     = 1'b0;
        isRamOp   = 1'b0;
        isRamRead = 1'b0;
        case (oprQ)
            ADD: begin
                aluOp   = ADDC;
                accWe   = 1'b1;
                carryWe = 1'b1;
            end
            SUB: begin
                aluOp   = SUBB;
                accWe   = 1'b1;
                carryWe = 1'b1;
            end
            LD:  accWe = 1'b1;
            XCH: begin
                accWe = 1'b1;
                regWe = (state == EXEC);
            end
            INC: begin
                aluOp = INCB;
                regWe = (state == EXEC);
            end
            LDM: begin
                aluB  = opaQ;   // Immediate operand
                accWe = 1'b1;
            end
            SRC: isSrc = opaQ[0];   // Even opa is FIM, not kept
            EGRP: begin
                aluB = mem.rdata;
                case (eOpE'(opaQ))
                    WRM: isRamOp = 1'b1;
                    RDM: begin
                        isRamOp   = 1'b1;
                        isRamRead = 1'b1;
                        accWe     = 1'b1;
                    end
                    ADM, SBM: begin
                        isRamOp   = 1'b1;
                        isRamRead = 1'b1;
                        aluOp     = (eOpE'(opaQ) == ADM) ? ADDC : SUBB;
                        accWe     = 1'b1;
                        carryWe   = 1'b1;
                    end
                    default: ;
                endcase
            end
            FGRP: begin
                case (fOpE'(opaQ))
                    CLB: {aluOp, accWe, carryWe} = {CLR, 2'b11};
                    CLC: {carryWe, carryNext} = 2'b10;
                    IAC: {aluOp, accWe, carryWe} = {INCA, 2'b11};
                    CMC: {carryWe, carryNext} = {1'b1, ~carry};
                    CMA: {aluOp, accWe} = {CMPA, 1'b1};
                    RAL: {aluOp, accWe, carryWe} = {ROTL, 2'b11};
                    RAR: {aluOp, accWe, carryWe} = {ROTR, 2'b11};
                    TCC: {aluOp, accWe, carryWe} = {TCCA, 2'b11};
                    DAC: {aluOp, accWe, carryWe} = {DECA, 2'b11};
                    STC: {carryWe, carryNext} = 2'b11;
                    default: ;
                endcase
            end
            default: ;   // Dropped codes run as no-ops
        endcase
    end

    // ------------------------------------------------------------
    // Handshake FSM and architectural state
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= IDLE;
            acc       <= '0;
            carry     <= 1'b0;
            addrLatch <= '0;
        end else begin
            case (state)
                IDLE: if (instValid) state <= EXEC;
                EXEC: begin
                    if (isRamOp) begin
                        state <= MEMREQ;
                    end else begin
                        state <= IDLE;
                        if (accWe) acc <= aluResult;
                        if (carryWe) carry <= carryNext;
                        if (isSrc) addrLatch <= regRdata;
                    end
                end
                MEMREQ: if (mem.ready) state <= isRamRead ? MEMWAIT : IDLE;
                MEMWAIT: begin
                    if (mem.rvalid) begin   // ALU already sees RAM data
                        state <= IDLE;
                        if (accWe) acc <= aluResult;
                        if (carryWe) carry <= carryNext;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: rtl/nibbleCore.sv
`timescale 1ns/100ps

module nibbleCore #(
    parameter int RamDepth = memPkg::ramDepth
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              instValid,
    input  isaPkg::nibble_t   instOpr,
    input  isaPkg::nibble_t   instOpa,
    output logic              instReady,
    input  logic              hostValid,
    input  logic              hostWrite,
    input  memPkg::ramAddr_t  hostAddr,
    input  isaPkg::nibble_t   hostWdata,
    output logic              hostReady,
    output isaPkg::nibble_t   hostRdata,
    output logic              hostRvalid,
    output isaPkg::nibble_t   acc,
    output logic              carry
);
    import isaPkg::*;

    logic [regIdxW-1:0]          regIdx;
    logic                        regWe;
    nibble_t                     regWdata;
    nibble_t                     regRdata;
    aluOpE                       aluOp;
    nibble_t                     aluB;
    nibble_t                     aluResult;
    logic                        aluCarry;
    logic                        ramWe;
    logic [$clog2(RamDepth)-1:0] ramAddr;
    nibble_t                     ramWdata;
    nibble_t                     ramRdata;

    memReqIf coreMem ();
    memReqIf hostMem ();

    // Host port onto its request bundle
    assign hostMem.valid = hostValid;
    assign hostMem.write = hostWrite;
    assign hostMem.addr  = hostAddr;
    assign hostMem.wdata = hostWdata;
    assign hostReady     = hostMem.ready;
    assign hostRdata     = hostMem.rdata;
    assign hostRvalid    = hostMem.rvalid;

    instDecoder uDecoder (
        .clk       (clk),
        .rstN      (rstN),
        .instValid (instValid),
        .instOpr   (instOpr),
        .instOpa   (instOpa),
        .instReady (instReady),
        .regIdx    (regIdx),
        .regRdata  (regRdata),
        .regWe     (regWe),
        .regWdata  (regWdata),
        .aluOp     (aluOp),
        .aluB      (aluB),
        .aluResult (aluResult),
        .aluCarry  (aluCarry),
        .acc       (acc),
        .carry     (carry),
        .mem       (coreMem.requester)
    );

    nibbleAlu uAlu (
        .aluOp     (aluOp),
        .accIn     (acc),
        .aluB      (aluB),
        .carryIn   (carry),
        .aluResult (aluResult),
        .aluCarry  (aluCarry)
    );

    regFile uRegFile (
        .clk   (clk),
        .rstN  (rstN),
        .rdIdx (regIdx),
        .we    (regWe),
        .wrIdx (regIdx),
        .wdata (regWdata),
        .rdata (regRdata)
    );

    ramArbiter #(.RamDepth(RamDepth)) uArbiter (
        .clk      (clk),
        .rstN     (rstN),
        .core     (coreMem.arbiter),
        .host     (hostMem.arbiter),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    dataRam #(.RamDepth(RamDepth)) uDataRam (
        .clk   (clk),
        .we    (ramWe),
        .addr  (ramAddr),
        .wdata (ramWdata),
        .rdata (ramRdata)
    );

endmodule

// File: tests/nibbleCore_chk.sv
`timescale 1ns/100ps

module nibbleCore_chk (
    input logic       clk,
    input logic       rstN,
    input logic       instValid,
    input logic       instReady,
    input logic       hostValid,
    input logic       hostReady,
    input logic       hostWrite,
    input logic [3:0] hostAddr,
    input logic [3:0] hostWdata,
    input logic       hostRvalid,
    input logic [3:0] acc,
    input logic       carry
);

    int failCount = 0;

    // Architectural state held clear while in reset
    resetState: assert property (@(posedge clk)
        !rstN |-> instReady && !carry && acc == 4'h0 && !hostRvalid)
        else begin
            failCount = failCount + 1;
            $error("core state not cleared during reset");
        end

    acceptDrop: assert property (@(posedge clk) disable iff (!rstN)
        instValid && instReady |=> !instReady)
        else begin
            failCount = failCount + 1;
            $error("instReady stayed high after an accept");
        end

    // ------------------------------------------------------------
    // Host port protocol
    // ------------------------------------------------------------
    readResp: assert property (@(posedge clk) disable iff (!rstN)
        hostValid && hostReady && !hostWrite |=> hostRvalid)
        else begin
            failCount = failCount + 1;
            $error("no hostRvalid after a host read");
        end

    noStrayResp: assert property (@(posedge clk) disable iff (!rstN)
        hostRvalid |-> $past(hostValid && hostReady && !hostWrite))
        else begin
            failCount = failCount + 1;
            $error("hostRvalid without a host read");
        end

    hostHold: assert property (@(posedge clk) disable iff (!rstN)
        hostValid && !hostReady |=> hostValid && $stable({hostWrite, hostAddr, hostWdata}))
        else begin
            failCount = failCount + 1;
            $error("host request changed before its grant");
        end

endmodule

bind nibbleCore nibbleCore_chk chk (
    .clk        (clk),
    .rstN       (rstN),
    .instValid  (instValid),
    .instReady  (instReady),
    .hostValid  (hostValid),
    .hostReady  (hostReady),
    .hostWrite  (hostWrite),
    .hostAddr   (hostAddr),
    .hostWdata  (hostWdata),
    .hostRvalid (hostRvalid),
    .acc        (acc),
    .carry      (carry)
);

// File: tests/nibbleCore_tb.sv
`timescale 1ns/100ps

module nibbleCore_tb;
    import isaPkg::*;

    localparam int ClkPeriod = 20;
    localparam int TestOps   = 560;   // Instructions plus host accesses, rounded up
    localparam int TimeLimit = TestOps * 40 * ClkPeriod;

    logic       clk;
    logic       rstN;
    logic       instValid;
    logic [3:0] instOpr;
    logic [3:0] instOpa;
    logic       instReady;
    logic       hostValid;
    logic       hostWrite;
    logic [3:0] hostAddr;
    logic [3:0] hostWdata;
    logic       hostReady;
    logic [3:0] hostRdata;
    logic       hostRvalid;
    logic [3:0] acc;
    logic       carry;

    logic [31:0] lfsr = 32'h15354102;
    int          valueErrors;
    int          protoErrors;
    int          hostCount;
    logic        coreDone;

    // Reference model state
    logic [3:0] mAcc;
    logic       mCarry;
    logic [3:0] mAddr;
    logic [3:0] mRegs [16];
    logic [3:0] mRam [16];

    // Concurrent phase programs
    logic [3:0] coreOpr [36];
    logic [3:0] coreOpa [36];
    logic       hostW [32];
    logic [3:0] hostA [32];
    logic [3:0] hostD [32];

    nibbleCore dut (
        .clk        (clk),
        .rstN       (rstN),
        .instValid  (instValid),
        .instOpr    (instOpr),
        .instOpa    (instOpa),
        .instReady  (instReady),
        .hostValid  (hostValid),
        .hostWrite  (hostWrite),
        .hostAddr   (hostAddr),
        .hostWdata  (hostWdata),
        .hostReady  (hostReady),
        .hostRdata  (hostRdata),
        .hostRvalid (hostRvalid),
        .acc        (acc),
        .carry      (carry)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random source and small helpers
    // ------------------------------------------------------------
    function automatic logic nextBit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // Taps 32,22,2,1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [3:0] randNibble();
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < 4; i++) begin
            v = {v[2:0], nextBit()};
        end
        return v;
    endfunction

    function automatic logic [3:0] regGroupOp(input int sel);
        case (sel)
            0:       return ADD;
            1:       return SUB;
            2:       return LD;
            3:       return XCH;
            4:       return INC;
            default: return LDM;
        endcase
    endfunction

    function automatic logic [3:0] ramGroupOp(input int sel);
        case (sel)
            0:       return WRM;
            1:       return RDM;
            2:       return ADM;
            default: return SBM;
        endcase
    endfunction

    task automatic checkVal(input string name, input logic [3:0] got, input logic [3:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Reference model, one instruction
    // ------------------------------------------------------------
    task automatic modelExec(input logic [3:0] opr, input logic [3:0] opa);
        logic [3:0] held;
        case (opr)
            ADD: {mCarry, mAcc} = {1'b0, mAcc} + {1'b0, mRegs[opa]} + {4'b0, mCarry};
            SUB: {mCarry, mAcc} = {1'b0, mAcc} + {1'b0, ~mRegs[opa]} + {4'b0, mCarry};
            LD:  mAcc = mRegs[opa];
            XCH: begin
                held       = mAcc;
                mAcc       = mRegs[opa];
                mRegs[opa] = held;
            end
            INC: mRegs[opa] = mRegs[opa] + 4'd1;   // Carry untouched
            LDM: mAcc = opa;
            SRC: if (opa[0]) mAddr = mRegs[opa];   // Even opa is FIM
            EGRP: begin
                case (opa)
                    4'h0: mRam[mAddr] = mAcc;
                    4'h8: {mCarry, mAcc} = {1'b0, mAcc} + {1'b0, ~mRam[mAddr]} + {4'b0, mCarry};
                    4'h9: mAcc = mRam[mAddr];
                    4'hB: {mCarry, mAcc} = {1'b0, mAcc} + {1'b0, mRam[mAddr]} + {4'b0, mCarry};
                    default: ;
                endcase
            end
            FGRP: begin
                case (opa)
                    4'h0: begin
                        mAcc   = 4'h0;
                        mCarry = 1'b0;
                    end
                    4'h1: mCarry = 1'b0;
                    4'h2: {mCarry, mAcc} = {1'b0, mAcc} + 5'd1;
                    4'h3: mCarry = ~mCarry;
                    4'h4: mAcc = ~mAcc;
                    4'h5: {mCarry, mAcc} = {mAcc, mCarry};
                    4'h6: {mAcc, mCarry} = {mCarry, mAcc};
                    4'h7: begin
                        mAcc   = {3'b000, mCarry};
                        mCarry = 1'b0;
                    end
                    4'h8: {mCarry, mAcc} = {1'b0, mAcc} + 5'h0F;   // Set when no borrow
                    4'hA: mCarry = 1'b1;
                    default: ;
                endcase
            end
            default: ;   // Dropped codes
        endcase
    endtask

    // ------------------------------------------------------------
    // Bus drivers
    // ------------------------------------------------------------
    task automatic sendInst(input logic [3:0] opr, input logic [3:0] opa);
        logic accepted;
        logic ramOp;
        int   waits;
        accepted = 1'b0;
        waits    = 0;
        ramOp    = (opr == EGRP) && (opa == 4'h0 || opa == 4'h8 || opa == 4'h9 || opa == 4'hB);
        instValid = 1'b1;
        instOpr   = opr;
        instOpa   = opa;
        while (!accepted) begin
            @(negedge clk);
            accepted = instReady;
            @(posedge clk);
            #2;
        end
        instValid = 1'b0;
        @(negedge clk);
        while (!instReady) begin
            waits++;
            @(negedge clk);
        end
        modelExec(opr, opa);
        checkVal("acc", acc, mAcc);
        checkBit("carry", carry, mCarry);
        assert (ramOp || waits == 1) else begin
            protoErrors++;
            $display("instruction %h%h took %0d cycles instead of one", opr, opa, waits);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic hostAccess(input logic isWrite, input logic [3:0] addr, input logic [3:0] data);
        logic granted;
        granted   = 1'b0;
        hostValid = 1'b1;
        hostWrite = isWrite;
        hostAddr  = addr;
        hostWdata = data;
        while (!granted) begin
            @(negedge clk);
            granted = hostReady;
            @(posedge clk);
            #2;
        end
        hostValid = 1'b0;   // Now just past the transfer edge
        if (isWrite) begin
            mRam[addr] = data;
        end else begin
            checkBit("hostRvalid", hostRvalid, 1'b1);
            checkVal("hostRdata", hostRdata, mRam[addr]);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int         sel;
        logic [3:0] addr;
        rstN        = 1'b1;
        instValid   = 1'b0;
        instOpr     = 4'h0;
        instOpa     = 4'h0;
        hostValid   = 1'b0;
        hostWrite   = 1'b0;
        hostAddr    = 4'h0;
        hostWdata   = 4'h0;
        valueErrors = 0;
        protoErrors = 0;
        hostCount   = 0;
        coreDone    = 1'b0;
        mAcc        = 4'h0;
        mCarry      = 1'b0;
        mAddr       = 4'h0;
        for (int r = 0; r < 16; r++) begin
            mRegs[r] = 4'h0;
        end
        #1 rstN = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rstN = 1'b1;

        checkVal("acc", acc, 4'h0);
        checkBit("carry", carry, 1'b0);
        checkBit("instReady", instReady, 1'b1);
        checkBit("hostRvalid", hostRvalid, 1'b0);

        // Known RAM contents, odd stride covers every word
        for (int a = 0; a < 16; a++) begin
            hostAccess(1'b1, 4'(a), 4'(a * 7 + 3));
        end

        // Register preload then random ALU and carry group
        for (int r = 0; r < 16; r++) begin
            sendInst(LDM, randNibble());
            sendInst(XCH, 4'(r));
        end
        repeat (200) begin
            sel = int'({nextBit(), randNibble()}) % 17;
            if (sel < 6) begin
                sendInst(regGroupOp(sel), randNibble());
            end else begin
                sendInst(FGRP, 4'(sel - 6));   // CLB through STC
            end
        end

        // SRC and WRM, read back by the host
        addr = randNibble();
        sendInst(LDM, addr);
        sendInst(XCH, 4'h1);
        sendInst(SRC, 4'h1);
        sendInst(LDM, randNibble());
        sendInst(EGRP, WRM);
        hostAccess(1'b0, addr, 4'h0);

        // Host written words through RDM, ADM, SBM
        for (int k = 0; k < 9; k++) begin
            addr = randNibble();
            hostAccess(1'b1, addr, randNibble());
            sendInst(LDM, addr);
            sendInst(XCH, 4'h3);
            sendInst(SRC, 4'h3);
            sendInst(LDM, randNibble());
            sendInst(FGRP, nextBit() ? STC : CLC);
            case (k % 3)
                0:       sendInst(EGRP, RDM);
                1:       sendInst(EGRP, ADM);
                default: sendInst(EGRP, SBM);
            endcase
        end

        // ------------------------------------------------------------
        // Core in the lower half of RAM, host in the upper half
        // ------------------------------------------------------------
        for (int r = 0; r < 4; r++) begin
            sendInst(LDM, {1'b0, nextBit(), nextBit(), nextBit()});
            sendInst(XCH, 4'(2 * r + 1));
        end
        for (int i = 0; i < 12; i++) begin
            coreOpr[3 * i]     = SRC;
            coreOpa[3 * i]     = {1'b0, nextBit(), nextBit(), 1'b1};
            coreOpr[3 * i + 1] = LDM;
            coreOpa[3 * i + 1] = randNibble();
            coreOpr[3 * i + 2] = EGRP;
            coreOpa[3 * i + 2] = ramGroupOp(int'({nextBit(), nextBit()}));
        end
        for (int i = 0; i < 32; i++) begin
            hostW[i] = nextBit();
            hostA[i] = {1'b1, nextBit(), nextBit(), nextBit()};
            hostD[i] = randNibble();
        end
        fork
            begin
                for (int i = 0; i < 36; i++) begin
                    sendInst(coreOpr[i], coreOpa[i]);
                end
                coreDone = 1'b1;
            end
            begin
                while (!coreDone) begin
                    hostAccess(hostW[hostCount % 32], hostA[hostCount % 32],
                               hostD[hostCount % 32]);
                    hostCount++;
                end
            end
        join
        assert (hostCount >= 12) else begin
            protoErrors++;
            $display("host got only %0d accesses while the core used RAM", hostCount);
        end

        // Dropped codes must behave as no-ops
        sendInst(LDM, 4'h9);
        sendInst(FGRP, STC);
        sendInst(JUN, 4'h5);
        sendInst(JCN, 4'h1);
        sendInst(FIN, 4'h1);
        sendInst(JMS, 4'h2);
        sendInst(ISZ, 4'h3);
        sendInst(BBL, 4'h4);
        sendInst(NOP, 4'h0);
        sendInst(SRC, 4'h2);    // FIM
        sendInst(FGRP, 4'hD);   // DCL
        sendInst(FGRP, 4'h9);   // TCS
        sendInst(FGRP, 4'hB);   // DAA
        sendInst(EGRP, 4'h2);   // WRR
        for (int r = 0; r < 16; r++) begin
            sendInst(LD, 4'(r));
        end
        sendInst(EGRP, WRM);    // Address latch must be intact
        hostAccess(1'b0, mAddr, 4'h0);

        $display("errors: %0d value, %0d protocol, %0d assertion",
                 valueErrors, protoErrors, dut.chk.failCount);
        if (valueErrors + protoErrors + dut.chk.failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(TimeLimit);
        $display("timeout after %0d ns, the DUT stopped completing requests", TimeLimit);
        $display("errors: %0d value, %0d protocol, %0d assertion",
                 valueErrors, protoErrors, dut.chk.failCount);
        $display("sim failed");
        $finish;
    end

endmodule

// File: nibbleCore.f
rtl/isaPkg.sv
rtl/memPkg.sv
rtl/memReqIf.sv
rtl/nibbleAlu.sv
rtl/regFile.sv
rtl/dataRam.sv
rtl/ramArbiter.sv
rtl/instDecoder.sv
rtl/nibbleCore.sv
tests/nibbleCore_chk.sv
tests/nibbleCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the nibbleCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module nibbleCore_tb -f nibbleCore.f -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Raise the error limit so assertion failures reach the closing summary
./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" sim.log; then
    exit 0
fi
exit 1
